// ==== udp_seg.f ====
+incdir+common
common/udp_seg_pkg.sv
udp_seg/seg_ctrl.sv
udp_seg/seg_flit_build.sv
hw/axis_skid.sv
hw/udp_seg_top.sv
testbench/tb_clk_gen.sv
testbench/udp_seg_mon.sv
testbench/udp_seg_chk.sv
testbench/udp_seg_tb.sv

// ==== testbench/udp_seg_tb.sv ====
// testbench top for the udp segmentation offload, drives frames and checks against a reference model
`include "udp_seg_defs.svh"

module udp_seg_tb
    import udp_seg_pkg::*;
();

    logic  clk;
    logic  rst;
    flit_t in_data;
    keep_t in_keep;
    logic  in_valid;
    logic  in_ready;
    logic  in_last;
    flit_t out_data;
    keep_t out_keep;
    logic  out_valid;
    logic  out_ready;
    logic  out_last;

    logic [7:0]  frm [0:8191];        // input frame
    int          frm_len;
    logic [7:0]  frame_out [0:8191];  // one expected output frame
    flit_t       exp_d [0:255];
    keep_t       exp_k [0:255];
    logic        exp_l [0:255];
    ip_id_t      ref_id;
    logic [15:0] lfsr_q;
    logic [15:0] rdy_q;
    logic        stress;
    int          cycle_cnt;
    int          limit = 200;

    tb_clk_gen u_clk (.clk(clk), .rst(rst));

    udp_seg_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_keep   (in_keep),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_last   (in_last),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last)
    );

    udp_seg_mon u_mon (
        .clk       (clk),
        .rst       (rst),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last)
    );

    bind udp_seg_top udp_seg_chk u_chk (
        .clk        (clk),
        .rst        (rst),
        .in_ready   (in_ready),
        .skid_ready (skid_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_last   (out_last),
        .out_data   (out_data),
        .out_keep   (out_keep),
        .state      (u_ctrl.state)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return r;
    endfunction

    function automatic csum_t ip_csum(input logic [159:0] h);
        logic [31:0] s;
        int          i;
        s = '0;
        for (i = 0; i < 10; i++) begin
            s = s + h[i*16 +: 16];
        end
        while (s[31:16] != 0) begin
            s = s[15:0] + s[31:16];  // end-around carry
        end
        return ~s[15:0];
    endfunction

    function automatic void set16(input int ofs, input logic [15:0] v);
        frm[ofs] = v[15:8];
        frm[ofs+1] = v[7:0];
    endfunction

    function automatic void put16(input int ofs, input logic [15:0] v);
        frame_out[ofs] = v[15:8];
        frame_out[ofs+1] = v[7:0];
    endfunction

    function automatic int pack_flits(input int len, input int n);
        int f;
        int b;
        int nf;
        nf = (len + `FLIT_BYTES - 1) / `FLIT_BYTES;
        for (f = 0; f < nf; f++) begin
            exp_d[n] = '0;
            exp_k[n] = '0;
            for (b = 0; b < `FLIT_BYTES; b++) begin
                if (f*`FLIT_BYTES + b < len) begin
                    exp_d[n][b*8 +: 8] = frame_out[f*`FLIT_BYTES + b];
                    exp_k[n][b] = 1'b1;
                end
            end
            exp_l[n] = (f == nf - 1);
            n++;
        end
        return n;
    endfunction

    // expected output flits of the frame in frm, returns the flit count
    function automatic int seg_ref();
        int           n;
        int           ip_len;
        int           pay;
        int           off;
        int           cnt;
        int           i;
        logic         elig;
        logic [159:0] hv;
        n = 0;
        ip_len = {frm[`OFS_IP_LEN], frm[`OFS_IP_LEN+1]};
        elig = (frm_len > `FLIT_BYTES) &&
               ({frm[`OFS_ETHERTYPE], frm[`OFS_ETHERTYPE+1]} == `ETHERTYPE_IPV4) &&
               (frm[`OFS_VER_IHL][3:0] == 4'd5) && (frm[`OFS_IP_PROTO] == `IP_PROTO_UDP) &&
               (ip_len > `SEG_IP_LEN);
        if (!elig) begin
            for (i = 0; i < frm_len; i++) begin
                frame_out[i] = frm[i];
            end
            return pack_flits(frm_len, 0);
        end
        pay = ip_len - `IP_HDR_LEN - `UDP_HDR_LEN;
        off = 0;
        while (off < pay) begin
            cnt = (pay - off > `SEG_PAYLOAD) ? `SEG_PAYLOAD : pay - off;
            for (i = 0; i < `HDR_LEN; i++) begin
                frame_out[i] = frm[i];
            end
            for (i = 0; i < cnt; i++) begin
                frame_out[`HDR_LEN + i] = frm[`HDR_LEN + off + i];
            end
            put16(`OFS_IP_LEN, 16'(cnt + `IP_HDR_LEN + `UDP_HDR_LEN));
            put16(`OFS_IP_ID, ref_id);
            put16(`OFS_UDP_LEN, 16'(cnt + `UDP_HDR_LEN));
            put16(`OFS_UDP_CSUM, 16'h0000);
            put16(`OFS_IP_CSUM, 16'h0000);
            hv = '0;
            for (i = 0; i < `IP_HDR_LEN; i++) begin
                hv = {hv[151:0], frame_out[`ETH_HDR_LEN + i]};
            end
            put16(`OFS_IP_CSUM, ip_csum(hv));
            ref_id = ref_id + 1'b1;
            n = pack_flits(`HDR_LEN + cnt, n);
            off = off + cnt;
        end
        return n;
    endfunction

    task automatic make_frame(input logic [15:0] etype, input logic [7:0] proto,
                              input int ip_len, input int len);
        logic [159:0] hv;
        int           i;
        frm_len = len;
        for (i = 0; i < len; i++) begin
            frm[i] = rand_bits(8);
        end
        set16(`OFS_ETHERTYPE, etype);
        if (etype == `ETHERTYPE_IPV4) begin
            frm[`OFS_VER_IHL] = 8'h45;
            frm[`OFS_VER_IHL+1] = 8'h00;
            set16(`OFS_IP_LEN, 16'(ip_len));
            set16(20, 16'h4000);  // don't fragment
            frm[22] = 8'd64;
            frm[`OFS_IP_PROTO] = proto;
            set16(`OFS_IP_CSUM, 16'h0000);
            if (proto == `IP_PROTO_UDP) begin
                set16(`OFS_UDP_LEN, 16'(ip_len - `IP_HDR_LEN));
            end
            hv = '0;
            for (i = 0; i < `IP_HDR_LEN; i++) begin
                hv = {hv[151:0], frm[`ETH_HDR_LEN + i]};
            end
            set16(`OFS_IP_CSUM, ip_csum(hv));
        end
    endtask

    // entered and left 1 unit after a rising edge
    task automatic send_frame(input logic gaps);
        int   nflits;
        int   f;
        int   b;
        logic took;
        nflits = (frm_len + `FLIT_BYTES - 1) / `FLIT_BYTES;
        for (f = 0; f < nflits; f++) begin
            if (gaps && rand_bits(2) == 0) begin
                in_valid = 1'b0;
                repeat (rand_bits(2) + 1) @(posedge clk);
                #1;
            end
            for (b = 0; b < `FLIT_BYTES; b++) begin
                in_data[b*8 +: 8] = (f*`FLIT_BYTES + b < frm_len) ? frm[f*`FLIT_BYTES + b] : 8'h00;
                in_keep[b] = (f*`FLIT_BYTES + b < frm_len);
            end
            in_last = (f == nflits - 1);
            in_valid = 1'b1;
            took = 1'b0;
            while (!took) begin
                @(negedge clk);
                took = in_ready;
                @(posedge clk);
                #1;
            end
        end
        in_valid = 1'b0;
        in_last = 1'b0;
    endtask

    task automatic run_frame(input logic [15:0] etype, input logic [7:0] proto,
                             input int ip_len, input int len, input logic gaps);
        int n;
        int i;
        make_frame(etype, proto, ip_len, len);
        n = seg_ref();
        for (i = 0; i < n; i++) begin
            u_mon.expect_flit(exp_d[i], exp_k[i], exp_l[i]);
        end
        limit = limit + 4 * n;
        send_frame(gaps);
    endtask

    task automatic finish_test(input string name);
        while (u_mon.pending != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);  // room for stray flits
        #1;
        u_mon.report_test(name);
    endtask

    // out_ready low one cycle in four while stressed
    initial begin
        out_ready = 1'b1;
        rdy_q = 16'd52;
        forever begin
            @(posedge clk);
            #1;
            if (stress) begin
                out_ready = (rdy_q[1:0] != 2'b00);
                rdy_q = lfsr_step(lfsr_step(rdy_q));
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt <= limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles with %0d expected output flits not seen",
                 cycle_cnt, u_mon.pending);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        in_data = '0;
        in_keep = '0;
        in_valid = 1'b0;
        in_last = 1'b0;
        stress = 1'b0;
        ref_id = '0;
        lfsr_q = 16'd52;
        @(negedge rst);
        @(posedge clk);
        #1;
        run_frame(16'h86DD, 8'h00, 0, 300, 1'b0);
        run_frame(`ETHERTYPE_IPV4, `IP_PROTO_UDP, 46, 60, 1'b0);
        run_frame(`ETHERTYPE_IPV4, 8'h06, 3000, 3014, 1'b0);
        finish_test("pass_through");
        run_frame(`ETHERTYPE_IPV4, `IP_PROTO_UDP, 1500, 1514, 1'b0);
        finish_test("udp_1500_unchanged");
        run_frame(`ETHERTYPE_IPV4, `IP_PROTO_UDP, 4000, 4014, 1'b0);
        finish_test("seg_4000");
        run_frame(`ETHERTYPE_IPV4, `IP_PROTO_UDP, 2980, 2994, 1'b0);  // 8 bytes in last segment
        finish_test("seg_merge_end");
        stress = 1'b1;
        run_frame(`ETHERTYPE_IPV4, `IP_PROTO_UDP, 4000, 4014, 1'b1);
        run_frame(16'h86DD, 8'h00, 0, 300, 1'b1);
        run_frame(`ETHERTYPE_IPV4, `IP_PROTO_UDP, 2960, 2974, 1'b1);
        run_frame(`ETHERTYPE_IPV4, `IP_PROTO_UDP, 1600, 1614, 1'b1);
        finish_test("random_stalls");
        stress = 1'b0;
        run_frame(`ETHERTYPE_IPV4, `IP_PROTO_UDP, 3100, 3114, 1'b0);
        run_frame(`ETHERTYPE_IPV4, `IP_PROTO_UDP, 4000, 4014, 1'b0);
        finish_test("back_to_back_ids");
        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 u_mon.pass_cnt, u_mon.fail_cnt, u_dut.u_chk.err_cnt);
        if (u_mon.fail_cnt == 0 && u_dut.u_chk.err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/udp_seg_chk.sv ====
// stream handshake assertions, bound into the segmentation top level by the testbench
module udp_seg_chk
    import udp_seg_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       in_ready,
    input logic       skid_ready,
    input logic       out_valid,
    input logic       out_ready,
    input logic       out_last,
    input flit_t      out_data,
    input keep_t      out_keep,
    input seg_state_t state
);

    int err_cnt = 0;

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_keep) &&
                                    $stable(out_last))
        else begin
            err_cnt++;
            $error("output flit dropped or changed while out_ready was low");
        end

    // a merge takes no input and lasts one accepted cycle
    a_merge_stall: assert property (@(posedge clk) disable iff (rst)
        state == ST_MERGE && skid_ready |-> !in_ready ##1 (state != ST_MERGE))
        else begin
            err_cnt++;
            $error("merge cycle took input or did not end when the slice had room");
        end

    a_rst_quiet: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            err_cnt++;
            $error("out_valid high during reset");
        end

endmodule

// ==== testbench/udp_seg_mon.sv ====
// output stream monitor, compares every transferred flit with the expected queue and prints test lines
module udp_seg_mon
    import udp_seg_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input flit_t out_data,
    input keep_t out_keep,
    input logic  out_valid,
    input logic  out_ready,
    input logic  out_last
);

    flit_t exp_data [$];
    keep_t exp_keep [$];
    logic  exp_last [$];
    int    pending = 0;
    int    test_errs = 0;
    int    pass_cnt = 0;
    int    fail_cnt = 0;

    function automatic flit_t keep_mask(input keep_t k);
        flit_t m;
        int    b;
        for (b = 0; b < $bits(keep_t); b++) begin
            m[b*8 +: 8] = {8{k[b]}};
        end
        return m;
    endfunction

    task automatic expect_flit(input flit_t d, input keep_t k, input logic l);
        exp_data.push_back(d);
        exp_keep.push_back(k);
        exp_last.push_back(l);
        pending++;
    endtask

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            $display("test %s: ok", name);
            pass_cnt++;
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            fail_cnt++;
        end
        test_errs = 0;
    endtask

    // outputs are stable at the falling edge, transfer happens at the next rising one
    always @(negedge clk) begin : compare
        flit_t d;
        keep_t k;
        logic  l;
        flit_t m;
        if (!rst && out_valid && out_ready) begin
            if (pending == 0) begin
                $display("time %0t: output flit arrived while no flit was expected", $time);
                test_errs++;
            end else begin
                d = exp_data.pop_front();
                k = exp_keep.pop_front();
                l = exp_last.pop_front();
                pending--;
                m = keep_mask(k);  // bytes outside keep are don't care
                if ((out_data & m) !== (d & m)) begin
                    $display("Error at time %0t: out_data expected %h got %h",
                             $time, d & m, out_data & m);
                    test_errs++;
                end
                if (out_keep !== k) begin
                    $display("Error at time %0t: out_keep expected %h got %h", $time, k, out_keep);
                    test_errs++;
                end
                if (out_last !== l) begin
                    $display("Error at time %0t: out_last expected %b got %b", $time, l, out_last);
                    test_errs++;
                end
            end
        end
    end

endmodule

// ==== testbench/tb_clk_gen.sv ====
// testbench clock and reset source, 8 unit clock period with reset held for 8 cycles
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;  // released just after an edge
    end

endmodule

// ==== hw/udp_seg_top.sv ====
// udp segmentation offload top level, connects control, flit builder and output slice
module udp_seg_top
    import udp_seg_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  flit_t in_data,
    input  keep_t in_keep,
    input  logic  in_valid,
    output logic  in_ready,
    input  logic  in_last,
    output flit_t out_data,
    output keep_t out_keep,
    output logic  out_valid,
    input  logic  out_ready,
    output logic  out_last
);

    flit_kind_t kind;
    logic       load_hdr;
    logic       load_tail;
    byte_cnt_t  seg_ip_len;
    ip_id_t     seg_id;
    logic       flit_valid;
    logic       skid_ready;
    flit_t      build_data;
    keep_t      build_keep;
    logic       build_last;

    seg_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_last    (in_last),
        .skid_ready (skid_ready),
        .flit_valid (flit_valid),
        .kind       (kind),
        .load_hdr   (load_hdr),
        .load_tail  (load_tail),
        .seg_ip_len (seg_ip_len),
        .seg_id     (seg_id)
    );

    seg_flit_build u_build (
        .clk        (clk),
        .rst        (rst),
        .in_data    (in_data),
        .in_keep    (in_keep),
        .in_last    (in_last),
        .kind       (kind),
        .load_hdr   (load_hdr),
        .load_tail  (load_tail),
        .seg_ip_len (seg_ip_len),
        .seg_id     (seg_id),
        .build_data (build_data),
        .build_keep (build_keep),
        .build_last (build_last)
    );

    axis_skid u_skid (
        .clk        (clk),
        .rst        (rst),
        .flit_valid (flit_valid),
        .skid_ready (skid_ready),
        .build_data (build_data),
        .build_keep (build_keep),
        .build_last (build_last),
        .out_data   (out_data),
        .out_keep   (out_keep),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_last   (out_last)
    );

endmodule

// ==== hw/axis_skid.sv ====
// two-entry stream register slice, the only output register, absorbs downstream back-pressure
module axis_skid
    import udp_seg_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  flit_valid,
    output logic  skid_ready,
    input  flit_t build_data,
    input  keep_t build_keep,
    input  logic  build_last,
    output flit_t out_data,
    output keep_t out_keep,
    output logic  out_valid,
    input  logic  out_ready,
    output logic  out_last
);

    localparam int ENT_W = $bits(flit_t) + $bits(keep_t) + 1;

    logic [ENT_W-1:0] ent0;    // head, drives the outputs
    logic [ENT_W-1:0] ent1;
    logic [ENT_W-1:0] ent_in;
    logic [1:0]       count;
    logic             push;
    logic             pop;

    assign ent_in     = {build_last, build_keep, build_data};
    assign skid_ready = (count != 2'd2);
    assign out_valid  = (count != 2'd0);
    assign push       = flit_valid && skid_ready;
    assign pop        = out_valid && out_ready;

    assign {out_last, out_keep, out_data} = ent0;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= 2'd0;
        end else begin
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push && ((count == 2'd0) || ((count == 2'd1) && pop))) begin
            ent0 <= ent_in;
        end else if (pop && (count == 2'd2)) begin
            ent0 <= ent1;  // second entry moves up
        end
        if (push && (count == 2'd1) && !pop) begin
            ent1 <= ent_in;
        end
    end

endmodule

// ==== udp_seg/seg_flit_build.sv ====
// flit builder: holds header template and segment tail, rewrites header fields, forms output flits
`include "udp_seg_defs.svh"

module seg_flit_build
    import udp_seg_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  flit_t      in_data,
    input  keep_t      in_keep,
    input  logic       in_last,
    input  flit_kind_t kind,
    input  logic       load_hdr,
    input  logic       load_tail,
    input  byte_cnt_t  seg_ip_len,
    input  ip_id_t     seg_id,
    output flit_t      build_data,
    output keep_t      build_keep,
    output logic       build_last
);

    localparam int HDR_BITS  = `HDR_LEN * 8;
    localparam int FLIT_BITS = `FLIT_BYTES * 8;
    localparam keep_t HDR_KEEP = {{(`FLIT_BYTES - `HDR_LEN){1'b0}}, {`HDR_LEN{1'b1}}};

    logic [HDR_BITS-1:0]           hdr_q;
    logic [FLIT_BITS-HDR_BITS-1:0] tail_q;  // bytes 42..63 of the tail flit
    keep_t                         tail_keep_q;
    logic                          tail_last_q;

    flit_t               hdr_src;
    logic [HDR_BITS-1:0] new_hdr;
    csum_t               old_csum;
    byte_cnt_t           old_len;
    ip_id_t              old_id;
    byte_cnt_t           udp_len;
    logic [18:0]         csum_sum;
    logic [16:0]         csum_fold;
    csum_t               csum_new;

    always_ff @(posedge clk) begin
        if (load_hdr) begin
            hdr_q <= in_data[HDR_BITS-1:0];
        end
        if (load_tail) begin
            tail_q      <= in_data[FLIT_BITS-1:HDR_BITS];
            tail_keep_q <= in_keep;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail_last_q <= 1'b0;
        end else if (load_tail) begin
            tail_last_q <= in_last;
        end
    end

    // first flit rewrites the live header, merges use the stored one
    assign hdr_src  = (kind == KIND_FIRST) ? in_data : flit_t'(hdr_q);
    assign old_csum = be16(hdr_src, `OFS_IP_CSUM);
    assign old_len  = be16(hdr_src, `OFS_IP_LEN);
    assign old_id   = be16(hdr_src, `OFS_IP_ID);
    assign udp_len  = seg_ip_len - byte_cnt_t'(`IP_HDR_LEN);

    // incremental update over length and id
    assign csum_sum  = {3'b0, ~old_csum} + {3'b0, ~old_len} + {3'b0, seg_ip_len} +
                       {3'b0, ~old_id} + {3'b0, seg_id};
    assign csum_fold = {1'b0, csum_sum[15:0]} + {14'b0, csum_sum[18:16]};
    assign csum_new  = ~(csum_fold[15:0] + {15'b0, csum_fold[16]});

    always_comb begin
        new_hdr = hdr_src[HDR_BITS-1:0];
        new_hdr[`OFS_IP_LEN*8 +: 16]   = {seg_ip_len[7:0], seg_ip_len[15:8]};  // msb first on wire
        new_hdr[`OFS_IP_ID*8 +: 16]    = {seg_id[7:0], seg_id[15:8]};
        new_hdr[`OFS_IP_CSUM*8 +: 16]  = {csum_new[7:0], csum_new[15:8]};
        new_hdr[`OFS_UDP_LEN*8 +: 16]  = {udp_len[7:0], udp_len[15:8]};
        new_hdr[`OFS_UDP_CSUM*8 +: 16] = 16'h0000;
    end

    always_comb begin
        case (kind)
            KIND_FIRST: begin
                build_data = {in_data[FLIT_BITS-1:HDR_BITS], new_hdr};
                build_keep = in_keep;
                build_last = in_last;
            end
            KIND_TAIL: begin
                build_data = in_data;
                build_keep = HDR_KEEP;
                build_last = 1'b1;
            end
            KIND_MERGE: begin
                build_data = {tail_q, new_hdr};
                build_keep = tail_last_q ? tail_keep_q : '1;  // final merge ends the frame
                build_last = tail_last_q;
            end
            default: begin
                build_data = in_data;
                build_keep = in_keep;
                build_last = in_last;
            end
        endcase
    end

endmodule

// ==== udp_seg/seg_ctrl.sv ====
// segmentation control: classifies each frame and steps the flit builder through segments
`include "udp_seg_defs.svh"

module seg_ctrl
    import udp_seg_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  flit_t      in_data,
    input  logic       in_valid,
    output logic       in_ready,
    input  logic       in_last,
    input  logic       skid_ready,
    output logic       flit_valid,
    output flit_kind_t kind,
    output logic       load_hdr,
    output logic       load_tail,
    output byte_cnt_t  seg_ip_len,
    output ip_id_t     seg_id
);

    localparam int TAIL_SPARE = `FLIT_BYTES - `HDR_LEN;       // 22 bytes past a tail
    localparam int SEG_FRAME  = `ETH_HDR_LEN + `SEG_IP_LEN;   // full segment frame
    localparam int L4_HDRS    = `IP_HDR_LEN + `UDP_HDR_LEN;

    seg_state_t state;
    byte_cnt_t  rem_pay;    // datagram payload not yet consumed
    byte_cnt_t  rem_frame;  // bytes left in current segment frame
    ip_id_t     id_cnt;

    byte_cnt_t  hdr_ip_len;
    logic       eligible;
    logic       seg_end;
    logic       xfer;
    logic       merge_go;

    assign hdr_ip_len = be16(in_data, `OFS_IP_LEN);

    // ipv4, ihl 5, udp, oversized and more than one flit
    assign eligible = (be16(in_data, `OFS_ETHERTYPE) == `ETHERTYPE_IPV4) &&
                      (in_data[`OFS_VER_IHL*8 +: 4] == 4'd5) &&
                      (in_data[`OFS_IP_PROTO*8 +: 8] == `IP_PROTO_UDP) &&
                      (hdr_ip_len > byte_cnt_t'(`SEG_IP_LEN)) &&
                      !in_last;

    // this flit closes a full segment frame
    assign seg_end = (rem_frame <= byte_cnt_t'(`FLIT_BYTES)) &&
                     (rem_pay >= byte_cnt_t'(`HDR_LEN));

    assign in_ready   = skid_ready && (state != ST_MERGE);
    assign flit_valid = (state == ST_MERGE) || in_valid;
    assign xfer       = in_valid && in_ready;
    assign merge_go   = (state == ST_MERGE) && skid_ready;

    assign load_hdr  = xfer && (state == ST_IDLE) && eligible;
    assign load_tail = xfer && (state == ST_SEG) && seg_end;
    assign seg_id    = id_cnt;

    always_comb begin
        case (state)
            ST_IDLE:  kind = eligible ? KIND_FIRST : KIND_PASS;
            ST_SEG:   kind = seg_end ? KIND_TAIL : KIND_PASS;
            ST_MERGE: kind = KIND_MERGE;
            default:  kind = KIND_PASS;
        endcase
    end

    // first segment is always full, later ones take the remainder if shorter
    always_comb begin
        if ((state == ST_MERGE) && (rem_pay < byte_cnt_t'(`SEG_PAYLOAD))) begin
            seg_ip_len = rem_pay + byte_cnt_t'(L4_HDRS);
        end else begin
            seg_ip_len = byte_cnt_t'(`SEG_IP_LEN);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            rem_pay   <= '0;
            rem_frame <= '0;
            id_cnt    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (xfer) begin
                        if (eligible) begin
                            state     <= ST_SEG;
                            rem_pay   <= hdr_ip_len - byte_cnt_t'(L4_HDRS + TAIL_SPARE);
                            rem_frame <= byte_cnt_t'(SEG_FRAME - `FLIT_BYTES);
                            id_cnt    <= id_cnt + 1'b1;
                        end else if (!in_last) begin
                            state <= ST_PASS;
                        end
                    end
                end
                ST_PASS: begin
                    if (xfer && in_last) begin
                        state <= ST_IDLE;
                    end
                end
                ST_SEG: begin
                    if (xfer) begin
                        if (seg_end) begin
                            rem_pay <= rem_pay - byte_cnt_t'(`HDR_LEN);
                            // no payload past the tail ends the datagram here
                            state   <= (rem_pay == byte_cnt_t'(`HDR_LEN)) ? ST_IDLE : ST_MERGE;
                        end else begin
                            rem_pay   <= rem_pay - byte_cnt_t'(`FLIT_BYTES);
                            rem_frame <= rem_frame - byte_cnt_t'(`FLIT_BYTES);
                            if (in_last) begin
                                state <= ST_IDLE;
                            end
                        end
                    end
                end
                ST_MERGE: begin
                    if (merge_go) begin
                        id_cnt    <= id_cnt + 1'b1;
                        rem_pay   <= rem_pay - byte_cnt_t'(TAIL_SPARE);
                        rem_frame <= byte_cnt_t'(SEG_FRAME - `FLIT_BYTES);
                        // stored tail holds the rest of the datagram
                        if (rem_pay <= byte_cnt_t'(TAIL_SPARE)) begin
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_SEG;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== common/udp_seg_pkg.sv ====
// shared types of the udp segmentation datapath, imported by the rtl and the output monitor
`include "udp_seg_defs.svh"

package udp_seg_pkg;

    typedef logic [`FLIT_BYTES*8-1:0] flit_t;
    typedef logic [`FLIT_BYTES-1:0]   keep_t;
    typedef logic [15:0]              byte_cnt_t;
    typedef logic [15:0]              ip_id_t;
    typedef logic [15:0]              csum_t;

    typedef enum logic [1:0] {
        KIND_PASS,   // input flit as is
        KIND_FIRST,  // first flit of a segmented frame
        KIND_TAIL,   // closes a full segment
        KIND_MERGE   // new header plus stored tail bytes
    } flit_kind_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PASS,
        ST_SEG,
        ST_MERGE
    } seg_state_t;

    // big-endian 16-bit field starting at byte ofs
    function automatic logic [15:0] be16(input flit_t d, input int unsigned ofs);
        be16 = {d[ofs*8 +: 8], d[(ofs+1)*8 +: 8]};
    endfunction

endpackage

// ==== common/udp_seg_defs.svh ====
// header offsets, lengths and protocol codes for the udp segmentation offload, include where needed
`ifndef UDP_SEG_DEFS_SVH
`define UDP_SEG_DEFS_SVH

// sizes in bytes
`define FLIT_BYTES      64
`define ETH_HDR_LEN     14
`define IP_HDR_LEN      20
`define UDP_HDR_LEN     8
`define HDR_LEN         42
`define SEG_IP_LEN      1500  // largest ip datagram per segment
`define SEG_PAYLOAD     1472  // udp payload of a full segment

// protocol codes
`define ETHERTYPE_IPV4  16'h0800
`define IP_PROTO_UDP    8'h11

// byte offsets from the start of the frame
`define OFS_ETHERTYPE   12
`define OFS_VER_IHL     14
`define OFS_IP_LEN      16
`define OFS_IP_ID       18
`define OFS_IP_PROTO    23
`define OFS_IP_CSUM     24
`define OFS_UDP_LEN     38
`define OFS_UDP_CSUM    40

`endif
